// ==== dwconv_config.svh ====
`ifndef DWCONV_CONFIG_SVH
`define DWCONV_CONFIG_SVH

// input map and kernel geometry
`define DW_IFM_W      6
`define DW_KERNEL_W   3

// stride 1 and no padding
`define DW_OFM_W      (`DW_IFM_W - `DW_KERNEL_W + 1)
`define DW_CHANNELS   4

// data widths
`define DW_PIX_W      8
`define DW_ACC_W      20

// requantize shift after rectification
`define DW_OUT_SHIFT  4
// log2 of the 16 output pixels per channel
`define DW_POOL_SHIFT 4

// ram address widths
`define DW_IFM_AW     6
`define DW_WGT_AW     4

`endif

// ==== dwconv_pkg.sv ====
`include "dwconv_config.svh"

package dwconv_pkg;

    // one unsigned activation byte
    typedef logic [`DW_PIX_W-1:0] pixel_t;

    // one signed kernel weight
    typedef logic signed [`DW_PIX_W-1:0] weight_t;

    // four packed channels, channel 0 in bits 7:0
    typedef logic [`DW_CHANNELS*`DW_PIX_W-1:0] word_t;

    // nine products of 9x8 bits fit with margin
    typedef logic signed [`DW_ACC_W-1:0] acc_t;

    // sixteen full-scale pixels per channel
    typedef logic [`DW_PIX_W+`DW_POOL_SHIFT-1:0] pool_sum_t;

    typedef logic [`DW_IFM_AW-1:0] ifm_addr_t;
    typedef logic [`DW_WGT_AW-1:0] wgt_addr_t;

    // window generator states
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_RUN,
        GEN_DRAIN,
        GEN_DONE
    } gen_state_t;

endpackage

// ==== feature_ram.sv ====
`timescale 1ns/1ps

module feature_ram #(
    parameter int ADDR_W = 6,
    parameter int DEPTH  = 36
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  dwconv_pkg::word_t wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output dwconv_pkg::word_t rd_data
);
    import dwconv_pkg::*;

    // one word per pixel or per kernel tap
    word_t mem [DEPTH];

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== dw_window_addr_gen.sv ====
`timescale 1ns/1ps
`include "dwconv_config.svh"

module dw_window_addr_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  last_out,
    output logic                  busy,
    output logic                  tap_valid,
    output logic                  win_first,
    output logic                  win_last,
    output dwconv_pkg::ifm_addr_t ifm_rd_addr,
    output dwconv_pkg::wgt_addr_t wgt_rd_addr
);
    import dwconv_pkg::*;

    localparam int KW_BITS = $clog2(`DW_KERNEL_W);
    localparam int OW_BITS = $clog2(`DW_OFM_W);
    localparam logic [KW_BITS-1:0] K_LAST = KW_BITS'(`DW_KERNEL_W - 1);
    localparam logic [OW_BITS-1:0] O_LAST = OW_BITS'(`DW_OFM_W - 1);

    gen_state_t state;

    // output position
    logic [OW_BITS-1:0] row;
    logic [OW_BITS-1:0] col;
    // tap inside the window, ky outer
    logic [KW_BITS-1:0] ky;
    logic [KW_BITS-1:0] kx;

    logic      k_end;
    logic      last_tap;
    logic      accept;
    ifm_addr_t ifm_row;

    assign k_end    = (kx == K_LAST) && (ky == K_LAST);
    assign last_tap = k_end && (col == O_LAST) && (row == O_LAST);

    // a pass may also start on the closing done cycle
    assign accept = start && ((state == GEN_IDLE) || (state == GEN_DONE));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= GEN_IDLE;
            row   <= '0;
            col   <= '0;
            ky    <= '0;
            kx    <= '0;
        end else begin
            case (state)
                GEN_IDLE, GEN_DONE: begin
                    if (accept) begin
                        state <= GEN_RUN;
                        row   <= '0;
                        col   <= '0;
                        ky    <= '0;
                        kx    <= '0;
                    end else begin
                        state <= GEN_IDLE;
                    end
                end
                GEN_RUN: begin
                    // one tap per cycle, windows row-major
                    if (kx != K_LAST) begin
                        kx <= kx + 1'b1;
                    end else begin
                        kx <= '0;
                        if (ky != K_LAST) begin
                            ky <= ky + 1'b1;
                        end else begin
                            ky <= '0;
                            if (col != O_LAST) begin
                                col <= col + 1'b1;
                            end else begin
                                col <= '0;
                                row <= (row == O_LAST) ? '0 : row + 1'b1;
                            end
                        end
                    end
                    if (last_tap) begin
                        state <= GEN_DRAIN;
                    end
                end
                // wait for the pooling result of this pass
                GEN_DRAIN: begin
                    if (last_out) begin
                        state <= GEN_DONE;
                    end
                end
                default: state <= GEN_IDLE;
            endcase
        end
    end

    assign busy      = (state == GEN_RUN) || (state == GEN_DRAIN);
    assign tap_valid = (state == GEN_RUN);
    assign win_first = tap_valid && (kx == '0) && (ky == '0);
    assign win_last  = tap_valid && k_end;

    // (row + ky) * map side + col + kx
    assign ifm_row     = ifm_addr_t'(row) + ifm_addr_t'(ky);
    assign ifm_rd_addr = ifm_row * ifm_addr_t'(`DW_IFM_W) + ifm_addr_t'(col) + ifm_addr_t'(kx);
    assign wgt_rd_addr = wgt_addr_t'(ky) * wgt_addr_t'(`DW_KERNEL_W) + wgt_addr_t'(kx);

endmodule

// ==== dw_mac_cluster.sv ====
`timescale 1ns/1ps
`include "dwconv_config.svh"

module dw_mac_cluster (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tap_valid,
    input  logic              win_first,
    input  logic              win_last,
    input  dwconv_pkg::word_t ifm_word,
    input  dwconv_pkg::word_t wgt_word,
    output logic              ofm_valid,
    output dwconv_pkg::word_t ofm_data
);
    import dwconv_pkg::*;

    // largest value a channel byte can carry
    localparam acc_t PIX_MAX = acc_t'((1 << `DW_PIX_W) - 1);

    // rectify, shift down, saturate to one byte
    function automatic pixel_t requant(input acc_t sum);
        acc_t shifted;
        shifted = sum >>> `DW_OUT_SHIFT;
        if (sum < 0) begin
            return '0;
        end
        if (shifted > PIX_MAX) begin
            return '1;
        end
        return pixel_t'(shifted);
    endfunction

    // one lane per channel byte
    for (genvar i = 0; i < `DW_CHANNELS; i++) begin : g_lane
        pixel_t  pix;
        weight_t wgt;
        acc_t    prod;
        acc_t    acc;
        acc_t    acc_next;
        pixel_t  res_q;

        assign pix = ifm_word[i*`DW_PIX_W +: `DW_PIX_W];
        assign wgt = wgt_word[i*`DW_PIX_W +: `DW_PIX_W];

        // pixel zero-extended, weight sign-extended
        assign prod = acc_t'({1'b0, pix}) * acc_t'(wgt);

        // first tap restarts the window sum
        assign acc_next = win_first ? prod : acc + prod;

        always_ff @(posedge clk) begin
            if (tap_valid) begin
                acc <= acc_next;
            end
        end

        // last tap is folded in before requantizing,
        // so the next window can load acc on the following cycle
        always_ff @(posedge clk) begin
            if (tap_valid && win_last) begin
                res_q <= requant(acc_next);
            end
        end

        assign ofm_data[i*`DW_PIX_W +: `DW_PIX_W] = res_q;
    end

    // one strobe per output pixel, aligned with res_q
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ofm_valid <= 1'b0;
        end else begin
            ofm_valid <= tap_valid && win_last;
        end
    end

endmodule

// ==== avg_pool.sv ====
`timescale 1ns/1ps
`include "dwconv_config.svh"

module avg_pool (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pass_start,
    input  logic              ofm_valid,
    input  dwconv_pkg::word_t ofm_data,
    output logic              done,
    output dwconv_pkg::word_t avg_data
);
    import dwconv_pkg::*;

    // output pixels seen in this pass
    logic [`DW_POOL_SHIFT-1:0] out_cnt;
    logic                      last_pix;

    assign last_pix = ofm_valid && (out_cnt == '1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_cnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= last_pix;
            if (pass_start) begin
                out_cnt <= '0;
            end else if (ofm_valid) begin
                out_cnt <= out_cnt + 1'b1;
            end
        end
    end

    for (genvar i = 0; i < `DW_CHANNELS; i++) begin : g_chan
        pixel_t    pix;
        pool_sum_t sum;
        pool_sum_t sum_next;
        pixel_t    avg_q;

        assign pix      = ofm_data[i*`DW_PIX_W +: `DW_PIX_W];
        assign sum_next = sum + pool_sum_t'(pix);

        always_ff @(posedge clk) begin
            if (pass_start) begin
                sum <= '0;
            end else if (ofm_valid) begin
                sum <= sum_next;
            end
        end

        // average includes the 16th pixel arriving this cycle
        always_ff @(posedge clk) begin
            if (last_pix) begin
                avg_q <= pixel_t'(sum_next >> `DW_POOL_SHIFT);
            end
        end

        assign avg_data[i*`DW_PIX_W +: `DW_PIX_W] = avg_q;
    end

endmodule

// ==== dwconv_pool_top.sv ====
`timescale 1ns/1ps
`include "dwconv_config.svh"

module dwconv_pool_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  ifm_wr_en,
    input  dwconv_pkg::ifm_addr_t ifm_wr_addr,
    input  dwconv_pkg::word_t     ifm_wr_data,
    input  logic                  wgt_wr_en,
    input  dwconv_pkg::wgt_addr_t wgt_wr_addr,
    input  dwconv_pkg::word_t     wgt_wr_data,
    output logic                  busy,
    output logic                  ofm_valid,
    output dwconv_pkg::word_t     ofm_data,
    output logic                  done,
    output dwconv_pkg::word_t     avg_data
);
    import dwconv_pkg::*;

    ifm_addr_t ifm_rd_addr;
    wgt_addr_t wgt_rd_addr;
    word_t     ifm_word;
    word_t     wgt_word;

    logic tap_valid;
    logic win_first;
    logic win_last;
    logic tap_valid_q;
    logic win_first_q;
    logic win_last_q;
    logic pass_start;

    // pooling sums clear only on an accepted start
    assign pass_start = start && !busy;

    feature_ram #(
        .ADDR_W (`DW_IFM_AW),
        .DEPTH  (`DW_IFM_W * `DW_IFM_W)
    ) u_ifm_ram (
        .clk     (clk),
        .wr_en   (ifm_wr_en),
        .wr_addr (ifm_wr_addr),
        .wr_data (ifm_wr_data),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_word)
    );

    feature_ram #(
        .ADDR_W (`DW_WGT_AW),
        .DEPTH  (`DW_KERNEL_W * `DW_KERNEL_W)
    ) u_wgt_ram (
        .clk     (clk),
        .wr_en   (wgt_wr_en),
        .wr_addr (wgt_wr_addr),
        .wr_data (wgt_wr_data),
        .rd_addr (wgt_rd_addr),
        .rd_data (wgt_word)
    );

    dw_window_addr_gen u_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .last_out    (done),
        .busy        (busy),
        .tap_valid   (tap_valid),
        .win_first   (win_first),
        .win_last    (win_last),
        .ifm_rd_addr (ifm_rd_addr),
        .wgt_rd_addr (wgt_rd_addr)
    );

    // tap marks follow the ram read latency
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tap_valid_q <= 1'b0;
            win_first_q <= 1'b0;
            win_last_q  <= 1'b0;
        end else begin
            tap_valid_q <= tap_valid;
            win_first_q <= win_first;
            win_last_q  <= win_last;
        end
    end

    dw_mac_cluster u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .tap_valid (tap_valid_q),
        .win_first (win_first_q),
        .win_last  (win_last_q),
        .ifm_word  (ifm_word),
        .wgt_word  (wgt_word),
        .ofm_valid (ofm_valid),
        .ofm_data  (ofm_data)
    );

    avg_pool u_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .pass_start (pass_start),
        .ofm_valid  (ofm_valid),
        .ofm_data   (ofm_data),
        .done       (done),
        .avg_data   (avg_data)
    );

endmodule

// ==== dwconv_props.sv ====
`timescale 1ns/1ps

module dwconv_props (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic ofm_valid,
    input logic done
);

    // output pixels only stream inside a pass
    a_valid_in_pass: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_valid |-> busy)
        else $error("ofm_valid high while busy is low");

    // done lasts one cycle
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    a_idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !busy)
        else $error("busy still high on the cycle after done");

endmodule

bind dwconv_pool_top dwconv_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .ofm_valid (ofm_valid),
    .done      (done)
);

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    // 4 ns period, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

endmodule

// ==== tb_dwconv_pool.sv ====
`timescale 1ns/1ps
`include "dwconv_config.svh"

module tb_dwconv_pool;
    import dwconv_pkg::*;

    localparam int NUM_PIX      = `DW_IFM_W * `DW_IFM_W;
    localparam int NUM_TAPS     = `DW_KERNEL_W * `DW_KERNEL_W;
    localparam int NUM_OUT      = `DW_OFM_W * `DW_OFM_W;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_PASSES   = 5;
    localparam int PASS_CYCLES  = 200;
    localparam int LOAD_CYCLES  = NUM_PIX + 8;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + NUM_PASSES * (PASS_CYCLES + LOAD_CYCLES) + 100;

    logic      clk;
    logic      rst_n;
    logic      start;
    logic      ifm_wr_en;
    ifm_addr_t ifm_wr_addr;
    word_t     ifm_wr_data;
    logic      wgt_wr_en;
    wgt_addr_t wgt_wr_addr;
    word_t     wgt_wr_data;
    logic      busy;
    logic      ofm_valid;
    word_t     ofm_data;
    logic      done;
    word_t     avg_data;

    // host copies of both rams and the expected results
    word_t ifm_model [NUM_PIX];
    word_t wgt_model [NUM_TAPS];
    word_t exp_ofm [NUM_OUT];
    word_t exp_avg;
    word_t fill_value = '0;
    logic  fill_check = 1'b0;

    int          errors     = 0;
    int          checks     = 0;
    int          total_out  = 0;
    int          total_done = 0;
    int          pass_base  = 0;
    int          done_base  = 0;
    logic        done_q     = 1'b0;
    int unsigned seed_dummy;

    tb_clk_gen u_clk_gen (
        .clk (clk)
    );

    dwconv_pool_top u_dwconv_pool_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ifm_wr_en   (ifm_wr_en),
        .ifm_wr_addr (ifm_wr_addr),
        .ifm_wr_data (ifm_wr_data),
        .wgt_wr_en   (wgt_wr_en),
        .wgt_wr_addr (wgt_wr_addr),
        .wgt_wr_data (wgt_wr_data),
        .busy        (busy),
        .ofm_valid   (ofm_valid),
        .ofm_data    (ofm_data),
        .done        (done),
        .avg_data    (avg_data)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // one channel of one window: rectify, shift, saturate
    function automatic pixel_t window_result(input int r, input int c, input int ch);
        int      sum;
        int      idx;
        pixel_t  p8;
        weight_t w8;
        sum = 0;
        for (int ky = 0; ky < `DW_KERNEL_W; ky++) begin
            for (int kx = 0; kx < `DW_KERNEL_W; kx++) begin
                idx = (r + ky) * `DW_IFM_W + c + kx;
                p8  = ifm_model[idx][ch*`DW_PIX_W +: `DW_PIX_W];
                w8  = wgt_model[ky*`DW_KERNEL_W + kx][ch*`DW_PIX_W +: `DW_PIX_W];
                sum += int'(p8) * int'(w8);
            end
        end
        if (sum < 0) begin
            return '0;
        end
        sum = sum >> `DW_OUT_SHIFT;
        if (sum > 255) begin
            return 8'hff;
        end
        return pixel_t'(sum);
    endfunction

    function automatic void build_model();
        int     sums [`DW_CHANNELS];
        pixel_t px;
        for (int ch = 0; ch < `DW_CHANNELS; ch++) begin
            sums[ch] = 0;
        end
        for (int r = 0; r < `DW_OFM_W; r++) begin
            for (int c = 0; c < `DW_OFM_W; c++) begin
                for (int ch = 0; ch < `DW_CHANNELS; ch++) begin
                    px = window_result(r, c, ch);
                    exp_ofm[r*`DW_OFM_W + c][ch*`DW_PIX_W +: `DW_PIX_W] = px;
                    sums[ch] += int'(px);
                end
            end
        end
        // floor of the channel mean
        for (int ch = 0; ch < `DW_CHANNELS; ch++) begin
            exp_avg[ch*`DW_PIX_W +: `DW_PIX_W] = pixel_t'(sums[ch] / NUM_OUT);
        end
    endfunction

    // mode 0 random, 1 full-scale positive, 2 weights all at -128
    task automatic load_maps(input int mode);
        for (int i = 0; i < NUM_PIX; i++) begin
            ifm_model[i] = (mode == 1) ? 32'hffffffff : $urandom;
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (mode == 1) begin
                wgt_model[i] = 32'h7f7f7f7f;
            end else if (mode == 2) begin
                wgt_model[i] = 32'h80808080;
            end else begin
                wgt_model[i] = $urandom;
            end
        end
        // kernel taps load alongside the first feature words
        for (int i = 0; i < NUM_PIX; i++) begin
            @(negedge clk);
            ifm_wr_en   = 1'b1;
            ifm_wr_addr = ifm_addr_t'(i);
            ifm_wr_data = ifm_model[i];
            wgt_wr_en   = (i < NUM_TAPS);
            if (i < NUM_TAPS) begin
                wgt_wr_addr = wgt_addr_t'(i);
                wgt_wr_data = wgt_model[i];
            end
        end
        @(negedge clk);
        ifm_wr_en = 1'b0;
        wgt_wr_en = 1'b0;
        build_model();
        fill_check = (mode != 0);
        fill_value = (mode == 1) ? 32'hffffffff : 32'h00000000;
    endtask

    task automatic run_pass(input int mode, input bit restart_mid);
        load_maps(mode);
        pass_base = total_out;
        done_base = total_done;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (restart_mid) begin
            repeat (40) @(negedge clk);
            check_value("busy", 32'(busy), 32'd1);
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
        end
        // a hang here is caught by the watchdog
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        check_value("ofm_count", 32'(total_out - pass_base), 32'(NUM_OUT));
        check_value("done_count", 32'(total_done - done_base), 32'd1);
    endtask

    // output monitor, samples between rising edges
    always @(negedge clk) begin
        if (rst_n) begin
            if (ofm_valid) begin
                if (total_out - pass_base < NUM_OUT) begin
                    check_value("ofm_data", ofm_data, exp_ofm[total_out - pass_base]);
                    if (fill_check) begin
                        check_value("ofm_data", ofm_data, fill_value);
                    end
                end else begin
                    errors++;
                    $display("ERROR: more than %0d output pixels in one pass at %0t",
                             NUM_OUT, $time);
                end
                total_out++;
            end
            if (done) begin
                total_done++;
                check_value("avg_data", avg_data, exp_avg);
            end
            if (done_q) begin
                check_value("busy", 32'(busy), 32'd0);
            end
            done_q = done;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        seed_dummy  = $urandom(32'h9bc5d5fd);
        rst_n       = 1'b0;
        start       = 1'b0;
        ifm_wr_en   = 1'b0;
        ifm_wr_addr = '0;
        ifm_wr_data = '0;
        wgt_wr_en   = 1'b0;
        wgt_wr_addr = '0;
        wgt_wr_data = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("ofm_valid", 32'(ofm_valid), 32'd0);
        check_value("done", 32'(done), 32'd0);

        run_pass(0, 1'b0);
        run_pass(1, 1'b0);
        run_pass(2, 1'b0);
        // second start mid-pass, then a fresh reload
        run_pass(0, 1'b1);
        run_pass(0, 1'b0);

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
dwconv_pkg.sv
feature_ram.sv
dw_window_addr_gen.sv
dw_mac_cluster.sv
avg_pool.sv
dwconv_pool_top.sv
dwconv_props.sv
tb_clk_gen.sv
tb_dwconv_pool.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module tb_dwconv_pool -f verilog.f -o sim_dwconv \
    || exit 1
result=$(./obj_dir/sim_dwconv 2>&1)
echo "$result"
echo "$result" | grep -qx "STATUS: PASS" && exit 0 || exit 1
